// File: logic/plic_pkg.sv
package plic_pkg;

    // Field widths.
    localparam int PRIO_W   = 3;
    localparam int SRC_ID_W = 5;
    localparam int ADDR_W   = 26;

    typedef logic [PRIO_W-1:0]   prio_t;
    // Id zero means no source.
    typedef logic [SRC_ID_W-1:0] src_id_t;
    typedef logic [31:0]         word_t;
    typedef logic [ADDR_W-1:0]   reg_addr_t;

    // Register map.
    localparam reg_addr_t PRIO_BASE = 26'h000_0000;
    localparam reg_addr_t PEND_ADDR = 26'h000_1000;
    localparam reg_addr_t TYPE_ADDR = 26'h000_1080;
    localparam reg_addr_t POL_ADDR  = 26'h000_1100;
    localparam reg_addr_t EN_BASE   = 26'h000_2000;
    localparam reg_addr_t EN_STRIDE = 26'h000_0080;
    localparam reg_addr_t TH_BASE   = 26'h020_0000;
    localparam reg_addr_t TH_STRIDE = 26'h000_1000;
    localparam reg_addr_t CLAIM_OFS = 26'h000_0004;

    // One word per source.
    function automatic reg_addr_t prio_addr(int src);
        return PRIO_BASE + reg_addr_t'(4 * src);
    endfunction

    function automatic reg_addr_t en_addr(int tgt);
        return EN_BASE + reg_addr_t'(tgt) * EN_STRIDE;
    endfunction

    function automatic reg_addr_t th_addr(int tgt);
        return TH_BASE + reg_addr_t'(tgt) * TH_STRIDE;
    endfunction

    // Claim/complete sits right after the threshold.
    function automatic reg_addr_t claim_addr(int tgt);
        return th_addr(tgt) + CLAIM_OFS;
    endfunction

endpackage

// File: logic/plic_cfg_if.sv
`timescale 1ns/10ps

interface plic_cfg_if #(
    parameter int NUM_SRC = 32,
    parameter int NUM_TGT = 2
);

    // Level when set, edge when clear.
    logic [NUM_SRC-1:0] int_type;
    // Active low when set.
    logic [NUM_SRC-1:0] int_pol;
    plic_pkg::prio_t    int_prio  [NUM_SRC];
    // Source mask per target.
    logic [NUM_SRC-1:0] int_en    [NUM_TGT];
    plic_pkg::prio_t    threshold [NUM_TGT];

    modport regs (
        output int_type,
        output int_pol,
        output int_prio,
        output int_en,
        output threshold
    );

    modport core (
        input  int_type,
        input  int_pol,
        input  int_prio,
        input  int_en,
        input  threshold
    );

endinterface

// File: logic/plic_claim_if.sv
`timescale 1ns/10ps

interface plic_claim_if;

    // Setup-phase strobe to the claim address.
    logic              claim_acc;
    logic              claim_wr;
    plic_pkg::src_id_t int_id;
    plic_pkg::src_id_t claim_id;

    modport regs (
        output claim_acc,
        output claim_wr,
        input  int_id
    );

    modport tgt (
        input  claim_acc,
        input  claim_wr,
        output int_id,
        output claim_id
    );

endinterface

// File: logic/plic_gateway.sv
`timescale 1ns/10ps

module plic_gateway #(
    parameter int SRC_ID  = 1,
    parameter int NUM_TGT = 2
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              src_i,
    input  logic              src_type_i,
    input  logic              src_pol_i,
    input  plic_pkg::src_id_t claim_ids_i  [NUM_TGT],
    input  plic_pkg::src_id_t cmplet_ids_i [NUM_TGT],
    output logic              pend_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PEND,
        ST_CLAIM
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   src_act;
    logic   src_lvl;
    logic   src_lvl_d;
    logic   src_edge;
    logic   src_pol_d;
    logic   is_req;
    logic   is_cancel;
    logic   is_claim;
    logic   is_cmplet;

    // Line in active-high form.
    assign src_act = src_i ^ src_pol_i;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            src_lvl   <= 1'b0;
            src_lvl_d <= 1'b0;
            src_edge  <= 1'b0;
            src_pol_d <= 1'b0;
        end else begin
            src_lvl   <= src_act;
            src_lvl_d <= src_lvl;
            src_edge  <= src_lvl & ~src_lvl_d;
            src_pol_d <= src_pol_i;
        end
    end

    assign is_req    = src_type_i ? src_lvl : src_edge;
    // Drop on level release or any polarity flip.
    assign is_cancel = (src_type_i & ~src_lvl) | (src_pol_i ^ src_pol_d);

    always_comb begin
        is_claim  = 1'b0;
        is_cmplet = 1'b0;
        for (int k = 0; k < NUM_TGT; k++) begin
            is_claim  = is_claim  | (claim_ids_i[k]  == plic_pkg::src_id_t'(SRC_ID));
            is_cmplet = is_cmplet | (cmplet_ids_i[k] == plic_pkg::src_id_t'(SRC_ID));
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  state_nxt = is_req ? ST_PEND : ST_IDLE;
            ST_PEND:  state_nxt = is_claim  ? ST_CLAIM :
                                  is_cancel ? ST_IDLE  : ST_PEND;
            ST_CLAIM: state_nxt = is_cmplet ? ST_IDLE : ST_CLAIM;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign pend_o = (state == ST_PEND);

endmodule

// File: logic/plic_prio_tree.sv
`timescale 1ns/10ps

module plic_prio_tree #(
    parameter int NUM_SRC = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [NUM_SRC-1:0] req_i,
    input  plic_pkg::prio_t    prio_i [NUM_SRC],
    output plic_pkg::prio_t    max_prio_o,
    output plic_pkg::src_id_t  max_id_o
);

    localparam int LVLS    = $clog2(NUM_SRC);
    // Flops sit behind the second compare level.
    localparam int REG_LVL = (LVLS > 1) ? 1 : 0;

    // Node count at a given tree level.
    function automatic int node_cnt(int lvl);
        int n;
        n = NUM_SRC;
        for (int l = 0; l < lvl; l++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    plic_pkg::prio_t   lvl_prio [LVLS+1][NUM_SRC];
    plic_pkg::src_id_t lvl_id   [LVLS+1][NUM_SRC];

    for (genvar i = 0; i < NUM_SRC; i++) begin : g_leaf
        assign lvl_prio[0][i] = req_i[i] ? prio_i[i] : '0;
        assign lvl_id[0][i]   = plic_pkg::src_id_t'(i);
    end

    for (genvar j = 0; j < LVLS; j++) begin : g_lvl
        localparam int CNT = node_cnt(j);
        for (genvar k = 0; k < CNT; k += 2) begin : g_node
            plic_pkg::prio_t   win_prio;
            plic_pkg::src_id_t win_id;

            if (k + 1 < CNT) begin : g_cmp
                logic take_right;
                // Ties stay with the lower id.
                assign take_right = lvl_prio[j][k+1] > lvl_prio[j][k];
                assign win_prio   = take_right ? lvl_prio[j][k+1] : lvl_prio[j][k];
                assign win_id     = take_right ? lvl_id[j][k+1] : lvl_id[j][k];
            end else begin : g_odd
                assign win_prio = lvl_prio[j][k];
                assign win_id   = lvl_id[j][k];
            end

            if (j == REG_LVL) begin : g_reg
                plic_pkg::prio_t   q_prio;
                plic_pkg::src_id_t q_id;

                always_ff @(posedge clk or negedge rstn) begin
                    if (!rstn) begin
                        q_prio <= '0;
                        q_id   <= '0;
                    end else begin
                        q_prio <= win_prio;
                        q_id   <= win_id;
                    end
                end

                assign lvl_prio[j+1][k/2] = q_prio;
                assign lvl_id[j+1][k/2]   = q_id;
            end else begin : g_comb
                assign lvl_prio[j+1][k/2] = win_prio;
                assign lvl_id[j+1][k/2]   = win_id;
            end
        end
    end

    assign max_prio_o = lvl_prio[LVLS][0];
    assign max_id_o   = lvl_id[LVLS][0];

endmodule

// File: logic/plic_target.sv
`timescale 1ns/10ps

module plic_target #(
    parameter int NUM_SRC = 32,
    parameter int TGT_ID  = 0
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [NUM_SRC-1:0] pend_i,
    plic_cfg_if.core           cfg,
    plic_claim_if.tgt          clm,
    output plic_pkg::src_id_t  cmplet_id_o,
    output logic               meip_o
);

    logic [NUM_SRC-1:0] req;
    plic_pkg::prio_t    max_prio;
    plic_pkg::src_id_t  max_id;
    plic_pkg::src_id_t  cand_id;

    assign req = pend_i & cfg.int_en[TGT_ID];

    plic_prio_tree #(
        .NUM_SRC    (NUM_SRC)
    ) u_tree (
        .clk        (clk),
        .rstn       (rstn),
        .req_i      (req),
        .prio_i     (cfg.int_prio),
        .max_prio_o (max_prio),
        .max_id_o   (max_id)
    );

    // Only sources strictly above threshold qualify.
    assign cand_id = (max_prio > cfg.threshold[TGT_ID]) ? max_id : '0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            clm.int_id <= '0;
        end else if (!clm.claim_acc && clm.claim_id == '0) begin
            // Non-preemptive hold while a claim is open.
            clm.int_id <= cand_id;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            clm.claim_id <= '0;
            cmplet_id_o  <= '0;
        end else begin
            cmplet_id_o <= '0;
            if (clm.claim_acc) begin
                clm.claim_id <= clm.claim_wr ? '0 : clm.int_id;
                if (clm.claim_wr) begin
                    cmplet_id_o <= clm.claim_id;
                end
            end
        end
    end

    assign meip_o = (clm.claim_id != clm.int_id);

endmodule

// File: logic/plic_regs.sv
`timescale 1ns/10ps

module plic_regs #(
    parameter int NUM_SRC = 32,
    parameter int NUM_TGT = 2
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  logic [31:0]        paddr_i,
    input  plic_pkg::word_t    pwdata_i,
    input  logic [NUM_SRC-1:0] pend_i,
    output plic_pkg::word_t    prdata_o,
    plic_cfg_if.regs           cfg,
    plic_claim_if.regs         clm [NUM_TGT]
);

    plic_pkg::reg_addr_t addr;
    logic                apb_setup;
    logic                apb_wr;
    plic_pkg::src_id_t   tgt_int_id [NUM_TGT];
    plic_pkg::word_t     rd_data;

    assign addr      = paddr_i[plic_pkg::ADDR_W-1:0];
    assign apb_setup = psel_i & ~penable_i;
    // Writes land at the end of the setup phase.
    assign apb_wr    = apb_setup & pwrite_i;

    for (genvar t = 0; t < NUM_TGT; t++) begin : g_clm
        assign clm[t].claim_acc = apb_setup && (addr == plic_pkg::claim_addr(t));
        assign clm[t].claim_wr  = pwrite_i;
        assign tgt_int_id[t]    = clm[t].int_id;
    end

    // Source 0 priority stays zero.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                cfg.int_prio[i] <= '0;
            end
        end else if (apb_wr) begin
            for (int i = 1; i < NUM_SRC; i++) begin
                if (addr == plic_pkg::prio_addr(i)) begin
                    cfg.int_prio[i] <= pwdata_i[plic_pkg::PRIO_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg.int_type <= '0;
            cfg.int_pol  <= '0;
        end else if (apb_wr) begin
            if (addr == plic_pkg::TYPE_ADDR) begin
                cfg.int_type <= pwdata_i[NUM_SRC-1:0];
            end
            if (addr == plic_pkg::POL_ADDR) begin
                cfg.int_pol <= pwdata_i[NUM_SRC-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int t = 0; t < NUM_TGT; t++) begin
                cfg.int_en[t]    <= '0;
                cfg.threshold[t] <= '0;
            end
        end else if (apb_wr) begin
            for (int t = 0; t < NUM_TGT; t++) begin
                if (addr == plic_pkg::en_addr(t)) begin
                    cfg.int_en[t] <= pwdata_i[NUM_SRC-1:0];
                end
                if (addr == plic_pkg::th_addr(t)) begin
                    cfg.threshold[t] <= pwdata_i[plic_pkg::PRIO_W-1:0];
                end
            end
        end
    end

    // Read mux, narrow fields zero-extended.
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (addr == plic_pkg::prio_addr(i)) begin
                rd_data = rd_data | plic_pkg::word_t'(cfg.int_prio[i]);
            end
        end
        if (addr == plic_pkg::PEND_ADDR) begin
            rd_data = rd_data | plic_pkg::word_t'(pend_i);
        end
        if (addr == plic_pkg::TYPE_ADDR) begin
            rd_data = rd_data | plic_pkg::word_t'(cfg.int_type);
        end
        if (addr == plic_pkg::POL_ADDR) begin
            rd_data = rd_data | plic_pkg::word_t'(cfg.int_pol);
        end
        for (int t = 0; t < NUM_TGT; t++) begin
            if (addr == plic_pkg::en_addr(t)) begin
                rd_data = rd_data | plic_pkg::word_t'(cfg.int_en[t]);
            end
            if (addr == plic_pkg::th_addr(t)) begin
                rd_data = rd_data | plic_pkg::word_t'(cfg.threshold[t]);
            end
            if (addr == plic_pkg::claim_addr(t)) begin
                rd_data = rd_data | plic_pkg::word_t'(tgt_int_id[t]);
            end
        end
    end

    // Captured at setup, valid through the access phase.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata_o <= '0;
        end else if (apb_setup) begin
            prdata_o <= rd_data;
        end
    end

endmodule

// File: logic/plic.sv
`timescale 1ns/10ps

module plic #(
    parameter int NUM_SRC = 32,
    parameter int NUM_TGT = 2
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  logic [31:0]        paddr_i,
    input  plic_pkg::word_t    pwdata_i,
    output plic_pkg::word_t    prdata_o,
    input  logic [NUM_SRC-1:0] ints_i,
    output logic [NUM_TGT-1:0] meip_o
);

    logic [NUM_SRC-1:0] pend;
    plic_pkg::src_id_t  claim_ids  [NUM_TGT];
    plic_pkg::src_id_t  cmplet_ids [NUM_TGT];

    plic_cfg_if #(
        .NUM_SRC (NUM_SRC),
        .NUM_TGT (NUM_TGT)
    ) u_cfg ();

    plic_claim_if u_clm [NUM_TGT] ();

    plic_regs #(
        .NUM_SRC   (NUM_SRC),
        .NUM_TGT   (NUM_TGT)
    ) u_regs (
        .clk       (clk),
        .rstn      (rstn),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pend_i    (pend),
        .prdata_o  (prdata_o),
        .cfg       (u_cfg.regs),
        .clm       (u_clm)
    );

    // Source 0 is reserved.
    assign pend[0] = 1'b0;

    for (genvar s = 1; s < NUM_SRC; s++) begin : g_gw
        plic_gateway #(
            .SRC_ID       (s),
            .NUM_TGT      (NUM_TGT)
        ) u_gw (
            .clk          (clk),
            .rstn         (rstn),
            .src_i        (ints_i[s]),
            .src_type_i   (u_cfg.int_type[s]),
            .src_pol_i    (u_cfg.int_pol[s]),
            .claim_ids_i  (claim_ids),
            .cmplet_ids_i (cmplet_ids),
            .pend_o       (pend[s])
        );
    end

    for (genvar t = 0; t < NUM_TGT; t++) begin : g_tgt
        plic_target #(
            .NUM_SRC     (NUM_SRC),
            .TGT_ID      (t)
        ) u_tgt (
            .clk         (clk),
            .rstn        (rstn),
            .pend_i      (pend),
            .cfg         (u_cfg.core),
            .clm         (u_clm[t].tgt),
            .cmplet_id_o (cmplet_ids[t]),
            .meip_o      (meip_o[t])
        );

        assign claim_ids[t] = u_clm[t].claim_id;
    end

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held for three cycles.
    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// File: sim/tb_plic.sv
`timescale 1ns/10ps

module tb_plic;

    localparam int NUM_SRC   = 32;
    localparam int NUM_TGT   = 2;
    localparam int MAX_CYCLE = 4000;

    logic                   clk;
    logic                   rstn;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            paddr;
    plic_pkg::word_t        pwdata;
    plic_pkg::word_t        prdata;
    logic [NUM_SRC-1:0]     ints;
    logic [NUM_TGT-1:0]     meip;

    plic_pkg::prio_t        prio_m [NUM_SRC];
    logic [NUM_SRC-1:0]     en_m   [NUM_TGT];
    plic_pkg::prio_t        th_m   [NUM_TGT];
    int                     cycles;

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    plic #(
        .NUM_SRC   (NUM_SRC),
        .NUM_TGT   (NUM_TGT)
    ) i_plic (
        .clk       (clk),
        .rstn      (rstn),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .ints_i    (ints),
        .meip_o    (meip)
    );

    // Lowest id among the highest priorities strictly above threshold.
    function automatic plic_pkg::src_id_t ref_claim(input logic [NUM_SRC-1:0] pend,
                                                    input logic [NUM_SRC-1:0] en,
                                                    input plic_pkg::prio_t prio [NUM_SRC],
                                                    input plic_pkg::prio_t th);
        plic_pkg::src_id_t best;
        plic_pkg::prio_t   best_prio;
        best      = '0;
        best_prio = th;
        for (int i = 1; i < NUM_SRC; i++) begin
            if (pend[i] && en[i] && prio[i] > best_prio) begin
                best_prio = prio[i];
                best      = plic_pkg::src_id_t'(i);
            end
        end
        return best;
    endfunction

    task automatic check_word(input string name, input plic_pkg::word_t got,
                              input plic_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_id(input string name, input plic_pkg::src_id_t got,
                            input plic_pkg::src_id_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_meip(input string name, input logic [NUM_TGT-1:0] got,
                              input logic [NUM_TGT-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input plic_pkg::reg_addr_t addr, input plic_pkg::word_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= 32'(addr);
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input plic_pkg::reg_addr_t addr, output plic_pkg::word_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= 32'(addr);
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Poll the pending register for a few reads.
    task automatic wait_pend(input plic_pkg::word_t exp);
        plic_pkg::word_t rd;
        for (int n = 0; n < 5; n++) begin
            apb_read(plic_pkg::PEND_ADDR, rd);
            if (rd === exp) begin
                break;
            end
        end
        check_word("pending", rd, exp);
    endtask

    task automatic wait_meip(input logic [NUM_TGT-1:0] exp);
        int n;
        n = 0;
        @(negedge clk);
        while (meip !== exp && n < 10) begin
            @(negedge clk);
            n++;
        end
        check_meip("meip_o", meip, exp);
    endtask

    task automatic claim_read(input int tgt, input plic_pkg::src_id_t exp);
        plic_pkg::word_t rd;
        apb_read(plic_pkg::claim_addr(tgt), rd);
        check_id("claim_id", plic_pkg::src_id_t'(rd), exp);
    endtask

    task automatic write_cfg();
        for (int i = 0; i < NUM_SRC; i++) begin
            apb_write(plic_pkg::prio_addr(i), plic_pkg::word_t'(prio_m[i]));
        end
        for (int t = 0; t < NUM_TGT; t++) begin
            apb_write(plic_pkg::en_addr(t), en_m[t]);
            apb_write(plic_pkg::th_addr(t), plic_pkg::word_t'(th_m[t]));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLE) begin
            $display("Run exceeded %0d cycles without finishing", MAX_CYCLE);
            $display("Test failed");
            $fatal(1);
        end
    end

    initial begin
        plic_pkg::word_t    w;
        plic_pkg::word_t    rd;
        logic [NUM_SRC-1:0] lines;
        plic_pkg::src_id_t  exp0;
        plic_pkg::src_id_t  exp1;
        void'($urandom(65632));
        cycles  = 0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        ints    = '0;
        @(posedge rstn);

        // Register readback.
        for (int i = 0; i < NUM_SRC; i++) begin
            w = $urandom;
            apb_write(plic_pkg::prio_addr(i), w);
            apb_read(plic_pkg::prio_addr(i), rd);
            check_word("prio", rd, (i == 0) ? '0 : (w & 32'h7));
        end
        w = $urandom;
        apb_write(plic_pkg::TYPE_ADDR, w);
        apb_read(plic_pkg::TYPE_ADDR, rd);
        check_word("type", rd, w);
        w = $urandom;
        apb_write(plic_pkg::POL_ADDR, w);
        apb_read(plic_pkg::POL_ADDR, rd);
        check_word("polarity", rd, w);
        for (int t = 0; t < NUM_TGT; t++) begin
            w = $urandom;
            apb_write(plic_pkg::en_addr(t), w);
            apb_read(plic_pkg::en_addr(t), rd);
            check_word("enable", rd, w);
            w = $urandom;
            apb_write(plic_pkg::th_addr(t), w);
            apb_read(plic_pkg::th_addr(t), rd);
            check_word("threshold", rd, w & 32'h7);
        end
        apb_write(plic_pkg::POL_ADDR, '0);
        apb_write(plic_pkg::TYPE_ADDR, '1);
        repeat (4) @(posedge clk);
        wait_pend('0);

        // Level sources and arbitration.
        for (int r = 0; r < 3; r++) begin
            lines = $urandom;
            lines[0] = 1'b0;
            lines[3] = 1'b1;
            for (int i = 0; i < NUM_SRC; i++) begin
                prio_m[i] = (i == 0) ? '0 : plic_pkg::prio_t'($urandom_range(7, 1));
            end
            en_m[0] = $urandom | 32'h8;
            en_m[1] = $urandom;
            th_m[0] = '0;
            th_m[1] = '0;
            write_cfg();
            @(posedge clk);
            ints <= lines;
            exp0 = ref_claim(lines, en_m[0], prio_m, th_m[0]);
            exp1 = ref_claim(lines, en_m[1], prio_m, th_m[1]);
            wait_meip({exp1 != '0, exp0 != '0});
            claim_read(0, exp0);
            @(negedge clk);
            check_meip("meip_o[0]", meip & 2'b01, 2'b00);
            @(posedge clk);
            ints <= '0;
            repeat (4) @(posedge clk);
            apb_write(plic_pkg::claim_addr(0), plic_pkg::word_t'(exp0));
            wait_pend('0);
        end

        // Edge source and complete.
        prio_m[5] = 3'd3;
        apb_write(plic_pkg::prio_addr(5), 32'd3);
        apb_write(plic_pkg::TYPE_ADDR, ~32'h20);
        apb_write(plic_pkg::en_addr(0), 32'h20);
        apb_write(plic_pkg::en_addr(1), '0);
        @(posedge clk);
        ints[5] <= 1'b1;
        @(posedge clk);
        ints[5] <= 1'b0;
        wait_pend(32'h20);
        claim_read(0, 5'd5);
        @(posedge clk);
        ints[5] <= 1'b1;
        @(posedge clk);
        ints[5] <= 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_meip("meip_o", meip, 2'b00);
        apb_read(plic_pkg::PEND_ADDR, rd);
        check_word("pending", rd, '0);
        apb_write(plic_pkg::claim_addr(0), 32'd5);
        @(posedge clk);
        ints[5] <= 1'b1;
        @(posedge clk);
        ints[5] <= 1'b0;
        wait_meip(2'b01);
        claim_read(0, 5'd5);
        apb_write(plic_pkg::claim_addr(0), 32'd5);

        // Threshold.
        apb_write(plic_pkg::TYPE_ADDR, '1);
        apb_write(plic_pkg::prio_addr(7), 32'd2);
        apb_write(plic_pkg::th_addr(0), 32'd2);
        apb_write(plic_pkg::en_addr(0), 32'h80);
        @(posedge clk);
        ints[7] <= 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_meip("meip_o", meip, 2'b00);
        apb_read(plic_pkg::PEND_ADDR, rd);
        check_word("pending", rd, 32'h80);
        claim_read(0, '0);
        @(posedge clk);
        ints[7] <= 1'b0;
        apb_write(plic_pkg::th_addr(0), '0);
        wait_pend('0);

        // Polarity.
        @(posedge clk);
        ints[10] <= 1'b1;
        apb_write(plic_pkg::POL_ADDR, 32'h600);
        wait_pend(32'h200);
        @(posedge clk);
        ints[10] <= 1'b0;
        apb_write(plic_pkg::POL_ADDR, '0);
        wait_pend('0);

        // Two targets with their own masks.
        lines = 32'h0000_f0f0;
        for (int i = 0; i < NUM_SRC; i++) begin
            prio_m[i] = (i == 0) ? '0 : plic_pkg::prio_t'($urandom_range(7, 1));
        end
        en_m[0] = 32'h0000_00f0;
        en_m[1] = 32'h0000_f0f0;
        th_m[0] = '0;
        th_m[1] = '0;
        write_cfg();
        @(posedge clk);
        ints <= lines;
        exp0 = ref_claim(lines, en_m[0], prio_m, th_m[0]);
        wait_meip(2'b11);
        claim_read(0, exp0);
        lines[exp0] = 1'b0;
        repeat (5) @(posedge clk);
        exp1 = ref_claim(lines, en_m[1], prio_m, th_m[1]);
        claim_read(1, exp1);
        @(posedge clk);
        ints <= '0;
        repeat (4) @(posedge clk);
        apb_write(plic_pkg::claim_addr(0), plic_pkg::word_t'(exp0));
        apb_write(plic_pkg::claim_addr(1), plic_pkg::word_t'(exp1));
        wait_pend('0);

        $display("Test passed");
        $finish;
    end

endmodule

// File: src.f
logic/plic_pkg.sv
logic/plic_cfg_if.sv
logic/plic_claim_if.sv
logic/plic_gateway.sv
logic/plic_prio_tree.sv
logic/plic_target.sv
logic/plic_regs.sv
logic/plic.sv
sim/tb_clk_gen.sv
sim/tb_plic.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/tb_plic: src.f
	verilator --binary --timing -f src.f --top-module tb_plic -o tb_plic

run: obj_dir/tb_plic
	./obj_dir/tb_plic | tee sim.log
	grep -q "Test passed" sim.log

lint:
	verilator --lint-only --timing -f src.f --top-module tb_plic

clean:
	rm -rf obj_dir sim.log
